//--- Makefile
# Verilator build and run of the router testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = noc_router_tb
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/noc_router_assertions.sv
// *************************************************************************
// Router assertions, bound into the router top
//   Output link never sends without a credit
//   Upstream credit pulses never exceed received flits
//   Each input is granted by at most one arbiter
// *************************************************************************

`include "noc_router_config.svh"

module noc_router_assertions
(
	input logic munoc_port_0,
	input logic munoc_port_4,
	input logic in0_valid,
	input logic in1_valid,
	input logic in0_credit,
	input logic in1_credit,
	input logic out0_valid,
	input logic out1_valid,
	input logic out0_credit,
	input logic out1_credit,
	input noc_route_pkg::in_grant_t out0_grant,
	input noc_route_pkg::in_grant_t out1_grant
);

	timeunit 1ns;
	timeprecision 100ps;

	import noc_route_pkg::*;

	// Link credits each output holds, as seen on the wires
	int out0_held;
	int out1_held;

	// Flits taken in and credits given back per input
	int in0_rx;
	int in0_ret;
	int in1_rx;
	int in1_ret;

	always_ff @(posedge munoc_port_0 or negedge munoc_port_4)
	begin
		if (munoc_port_4 == 1'b0)
		begin
			out0_held <= `NOC_BUFFER_DEPTH;
			out1_held <= `NOC_BUFFER_DEPTH;
			in0_rx <= 0;
			in0_ret <= 0;
			in1_rx <= 0;
			in1_ret <= 0;
		end
		else
		begin
			out0_held <= out0_held - int'(out0_valid) + int'(out0_credit);
			out1_held <= out1_held - int'(out1_valid) + int'(out1_credit);
			in0_rx <= in0_rx + int'(in0_valid);
			in0_ret <= in0_ret + int'(in0_credit);
			in1_rx <= in1_rx + int'(in1_valid);
			in1_ret <= in1_ret + int'(in1_credit);
		end
	end

	a_out0_credit: assert property (@(posedge munoc_port_0) disable iff (!munoc_port_4)
		out0_valid |-> out0_held > 0)
		else $error("output 0 sent a flit with no credit left");

	a_out1_credit: assert property (@(posedge munoc_port_0) disable iff (!munoc_port_4)
		out1_valid |-> out1_held > 0)
		else $error("output 1 sent a flit with no credit left");

	a_in0_return: assert property (@(posedge munoc_port_0) disable iff (!munoc_port_4)
		in0_credit |-> in0_ret < in0_rx)
		else $error("input 0 returned more credits than flits received");

	a_in1_return: assert property (@(posedge munoc_port_0) disable iff (!munoc_port_4)
		in1_credit |-> in1_ret < in1_rx)
		else $error("input 1 returned more credits than flits received");

	// Route is one-hot, so only one output may pop an input in a cycle
	a_grant0: assert property (@(posedge munoc_port_0) disable iff (!munoc_port_4)
		$onehot0({out1_grant[0], out0_grant[0]}))
		else $error("input 0 granted by both outputs");

	a_grant1: assert property (@(posedge munoc_port_0) disable iff (!munoc_port_4)
		$onehot0({out1_grant[1], out0_grant[1]}))
		else $error("input 1 granted by both outputs");

endmodule

bind noc_router noc_router_assertions u_assertions
(
	.munoc_port_0(munoc_port_0),
	.munoc_port_4(munoc_port_4),
	.in0_valid(in0_valid),
	.in1_valid(in1_valid),
	.in0_credit(in0_credit),
	.in1_credit(in1_credit),
	.out0_valid(out0_valid),
	.out1_valid(out1_valid),
	.out0_credit(out0_credit),
	.out1_credit(out1_credit),
	.out0_grant(out0_grant),
	.out1_grant(out1_grant)
);

//--- bench/noc_router_tb.sv
// *************************************************************************
// Router testbench
//   Clock, reset and LFSR packet generator
//   Upstream credit model and randomly delayed downstream credit return
//   Reference routing function and scoreboard with fairness check
// *************************************************************************

`include "noc_router_config.svh"

module noc_router_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import noc_flit_pkg::*;

	localparam int DEPTH = `NOC_BUFFER_DEPTH;
	localparam int TIMEOUT = 2000;
	localparam logic [31:0] SEED = 32'h884d_36d2;

	// Stimulus flit with the output its packet should use
	typedef struct packed
	{
		logic out;
		flit_t f;
	} tx_entry_t;

	// Expected flit tagged with the cycle it was driven
	typedef struct packed
	{
		logic [31:0] t;
		flit_t f;
	} exp_entry_t;

	// DUT links, index is the port number
	logic munoc_port_0 = 1'b0;
	logic munoc_port_4 = 1'b0;
	logic [1:0] in_valid = '0;
	flit_t in_flit [2] = '{default: '0};
	logic [1:0] in_credit;
	logic [1:0] out_valid;
	flit_t out_flit [2];
	logic [1:0] out_credit = '0;

	logic [31:0] stim_lfsr = SEED;
	logic [31:0] ret_lfsr = SEED;
	logic [31:0] cycle = '0;
	int errors = 0;

	// Stimulus per input, expected flits per (input, output) pair
	tx_entry_t tx_q [2][$];
	exp_entry_t exp_q [4][$];

	int sent [2] = '{0, 0};
	int returned [2] = '{0, 0};
	int delivered [2] = '{0, 0};
	int out_count [2] = '{0, 0};
	int owed [2] = '{0, 0};
	logic [14:0] seq [2] = '{'0, '0};
	logic [1:0] hold = '0;
	logic fair_check = 1'b0;

	// Packet state per output
	logic [1:0] in_pkt = '0;
	logic [1:0] pkt_src = '0;
	logic [1:0] last_src = '0;
	logic [1:0] have_last = '0;

	noc_router dut
	(
		.munoc_port_0(munoc_port_0),
		.munoc_port_4(munoc_port_4),
		.in0_valid(in_valid[0]),
		.in0_flit(in_flit[0]),
		.in0_credit(in_credit[0]),
		.in1_valid(in_valid[1]),
		.in1_flit(in_flit[1]),
		.in1_credit(in_credit[1]),
		.out0_valid(out_valid[0]),
		.out0_flit(out_flit[0]),
		.out0_credit(out_credit[0]),
		.out1_valid(out_valid[1]),
		.out1_flit(out_flit[1]),
		.out1_credit(out_credit[1])
	);

	// *********************************************************************
	// Reference model and random source
	// *********************************************************************

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Nodes 0 and 1 leave on output 0, nodes 2 and 3 on output 1
	function automatic int expected_output(input node_id_t dest);
		return (dest >= node_id_t'(2)) ? 1 : 0;
	endfunction

	task automatic rand_bits(input int n, output int unsigned v);
		v = 0;
		for (int k = 0; k < n; k++)
		begin
			stim_lfsr = lfsr_next(stim_lfsr);
			v = (v << 1) | stim_lfsr[0];
		end
	endtask

	// Mode 0 any node, 1 only output 0, 2 only output 1
	task automatic make_packets(input int i, input int count, input int mode, input bit single);
		int unsigned len;
		int unsigned d;
		int unsigned bd;
		node_id_t dest;
		tx_entry_t e;
		for (int p = 0; p < count; p++)
		begin
			rand_bits(2, len);
			if (single)
				len = 0;
			if (mode == 0)
				rand_bits(2, d);
			else
			begin
				rand_bits(1, d);
				d = (mode == 1) ? d : d + 2;
			end
			dest = node_id_t'(d);
			for (int k = 0; k <= int'(len); k++)
			begin
				// Body flits carry a random node that the router must ignore
				rand_bits(2, bd);
				e.out = 1'(expected_output(dest));
				e.f.last = (k == int'(len));
				e.f.dest = (k == 0) ? dest : node_id_t'(bd);
				e.f.payload = {i[0], seq[i]};
				seq[i] = seq[i] + 1'b1;
				tx_q[i].push_back(e);
			end
		end
	endtask

	// *********************************************************************
	// Upstream sender with credit model
	// *********************************************************************

	task automatic drive_input(input int i);
		tx_entry_t e;
		exp_entry_t x;
		int idle;
		idle = 0;
		while (tx_q[i].size() > 0 && idle < TIMEOUT)
		begin
			@(posedge munoc_port_0);
			// Credits held = depth minus flits not yet returned
			if (sent[i] - returned[i] < DEPTH)
			begin
				e = tx_q[i].pop_front();
				in_valid[i] <= 1'b1;
				in_flit[i] <= e.f;
				x.t = cycle;
				x.f = e.f;
				exp_q[i * 2 + int'(e.out)].push_back(x);
				sent[i] = sent[i] + 1;
				idle = 0;
			end
			else
			begin
				in_valid[i] <= 1'b0;
				idle = idle + 1;
			end
		end
		if (idle >= TIMEOUT)
		begin
			errors = errors + 1;
			$display("Timeout: input %0d never got an upstream credit back", i);
			tx_q[i].delete();
		end
		@(posedge munoc_port_0);
		in_valid[i] <= 1'b0;
	endtask

	function automatic int pending();
		return tx_q[0].size() + tx_q[1].size() + exp_q[0].size() + exp_q[1].size()
			+ exp_q[2].size() + exp_q[3].size() + owed[0] + owed[1];
	endfunction

	task automatic wait_drain(input string what);
		int t;
		t = 0;
		while (pending() > 0 && t < TIMEOUT)
		begin
			@(posedge munoc_port_0);
			t = t + 1;
		end
		if (t >= TIMEOUT)
		begin
			errors = errors + 1;
			$display("Timeout: %s traffic did not drain from the router", what);
		end
	endtask

	// *********************************************************************
	// Clock and cycle count
	// *********************************************************************

	initial
	begin
		forever #10 munoc_port_0 = ~munoc_port_0;
	end

	always @(posedge munoc_port_0)
		cycle <= cycle + 1;

	// One upstream credit per pulse
	always @(posedge munoc_port_0)
	begin
		for (int i = 0; i < 2; i++)
			if (in_credit[i])
				returned[i] <= returned[i] + 1;
	end

	// *********************************************************************
	// Scoreboard and downstream receiver
	// *********************************************************************

	always @(posedge munoc_port_0)
	begin
		int src;
		int other;
		int qi;
		exp_entry_t e;
		for (int o = 0; o < 2; o++)
		begin
			if (out_valid[o])
			begin
				// Source input rides in payload bit 15
				src = int'(out_flit[o].payload[15]);
				other = 1 - src;
				qi = src * 2 + o;
				assert (exp_q[qi].size() > 0)
				else
				begin
					errors = errors + 1;
					$display("error %0t: unexpected flit %h on output %0d", $time, out_flit[o], o);
				end
				if (exp_q[qi].size() > 0)
				begin
					e = exp_q[qi].pop_front();
					assert (out_flit[o] == e.f)
					else
					begin
						errors = errors + 1;
						$display("error %0t: output %0d got %h, expected %h",
							$time, o, out_flit[o], e.f);
					end
				end
				if (in_pkt[o])
				begin
					assert (src == int'(pkt_src[o]))
					else
					begin
						errors = errors + 1;
						$display("error %0t: packets interleaved on output %0d", $time, o);
					end
				end
				else
				begin
					// Other input waiting since before the grant, yet skipped again
					if (fair_check && have_last[o] && last_src[o] == src[0]
						&& exp_q[other * 2 + o].size() > 0)
					begin
						assert (exp_q[other * 2 + o][0].t + 3 > cycle)
						else
						begin
							errors = errors + 1;
							$display("error %0t: input %0d starved on output %0d",
								$time, other, o);
						end
					end
					pkt_src[o] = src[0];
				end
				in_pkt[o] = ~out_flit[o].last;
				if (out_flit[o].last)
				begin
					last_src[o] = src[0];
					have_last[o] = 1'b1;
				end
				delivered[src] = delivered[src] + 1;
				out_count[o] = out_count[o] + 1;
				owed[o] = owed[o] + 1;
			end
			// Random return delay, one pulse per delivered flit
			ret_lfsr = lfsr_next(ret_lfsr);
			if (owed[o] > 0 && !hold[o] && ret_lfsr[0])
			begin
				out_credit[o] <= 1'b1;
				owed[o] = owed[o] - 1;
			end
			else
				out_credit[o] <= 1'b0;
		end
	end

	// *********************************************************************
	// Test sequence
	// *********************************************************************

	initial
	begin
		int n;
		int o;
		int base;
		int t;
		repeat (10) @(posedge munoc_port_0);
		munoc_port_4 <= 1'b1;
		@(posedge munoc_port_0);

		// Single flit into an idle router
		make_packets(0, 1, 0, 1'b1);
		o = int'(tx_q[0][0].out);
		fork
			drive_input(0);
		join_none
		@(posedge munoc_port_0);
		// Driven here, registered on the output two edges on, sampled one edge later
		n = 0;
		do
		begin
			@(posedge munoc_port_0);
			n = n + 1;
		end
		while (!out_valid[o] && n < 20);
		assert (n == 3)
		else
		begin
			errors = errors + 1;
			$display("error %0t: latency of %0d edges, expected 3", $time, n);
		end
		wait_drain("latency");

		// Mixed destinations from both inputs
		make_packets(0, 12, 0, 1'b0);
		make_packets(1, 12, 0, 1'b0);
		fork
			drive_input(0);
			drive_input(1);
		join_none
		wait_drain("mixed");

		// Both inputs compete for output 0
		have_last = '0;
		fair_check = 1'b1;
		make_packets(0, 10, 1, 1'b0);
		make_packets(1, 10, 1, 1'b0);
		fork
			drive_input(0);
			drive_input(1);
		join_none
		wait_drain("contention");
		fair_check = 1'b0;

		// Withhold output 1 credits, then let them flow again
		hold[1] = 1'b1;
		base = out_count[1];
		make_packets(0, 4, 2, 1'b0);
		make_packets(1, 4, 2, 1'b0);
		fork
			drive_input(0);
			drive_input(1);
		join_none
		repeat (60) @(posedge munoc_port_0);
		assert (out_count[1] - base <= DEPTH)
		else
		begin
			errors = errors + 1;
			$display("error %0t: %0d flits sent without credit", $time, out_count[1] - base);
		end
		hold[1] = 1'b0;
		wait_drain("back-pressure");

		// Every upstream credit comes home
		t = 0;
		while ((returned[0] != sent[0] || returned[1] != sent[1]) && t < TIMEOUT)
		begin
			@(posedge munoc_port_0);
			t = t + 1;
		end
		if (t >= TIMEOUT)
		begin
			errors = errors + 1;
			$display("Timeout: upstream credits did not all return");
		end
		for (int i = 0; i < 2; i++)
		begin
			assert (delivered[i] == sent[i] && returned[i] == sent[i])
			else
			begin
				errors = errors + 1;
				$display("error %0t: input %0d sent %0d, delivered %0d, credits %0d",
					$time, i, sent[i], delivered[i], returned[i]);
			end
		end

		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- common/noc_flit_pkg.sv
// *************************************************************************
// Link flit description
//   Field widths and types of a flit
//   Field accessor functions for the last flag, destination and payload
// *************************************************************************

`include "noc_router_config.svh"

package noc_flit_pkg;

	// Payload is opaque to the router
	localparam int PAYLOAD_BITS = 16;
	localparam int NODE_BITS = `NOC_NODE_BITS;

	typedef logic [NODE_BITS-1:0] node_id_t;
	typedef logic [PAYLOAD_BITS-1:0] payload_t;

	// Layout from the top: last flag, destination, payload
	// Destination only carries meaning in a head flit
	typedef struct packed
	{
		logic last;
		node_id_t dest;
		payload_t payload;
	} flit_t;

	// Set on the final flit of a packet
	function automatic logic flit_last(input flit_t f);
		return f.last;
	endfunction

	function automatic node_id_t flit_dest(input flit_t f);
		return f.dest;
	endfunction

	function automatic payload_t flit_payload(input flit_t f);
		return f.payload;
	endfunction

endpackage

//--- common/noc_route_pkg.sv
// *************************************************************************
// Routing and flow control types
//   Input and output port indices
//   One-hot output requests and input grants
//   Credit counter type and its reset value
// *************************************************************************

`include "noc_router_config.svh"

package noc_route_pkg;

	localparam int NUM_INPUTS = `NOC_NUM_INPUTS;
	localparam int NUM_OUTPUTS = `NOC_NUM_OUTPUTS;

	// Port indices, at least one bit wide
	typedef logic [(NUM_INPUTS > 1 ? $clog2(NUM_INPUTS) : 1)-1:0] in_idx_t;
	typedef logic [(NUM_OUTPUTS > 1 ? $clog2(NUM_OUTPUTS) : 1)-1:0] out_idx_t;

	// One bit per output, one-hot when valid
	typedef logic [NUM_OUTPUTS-1:0] out_req_t;

	// One bit per input, one-hot or zero
	typedef logic [NUM_INPUTS-1:0] in_grant_t;

	// Credit counter
	typedef logic [`NOC_CREDIT_BITS-1:0] credit_t;

	// Downstream buffer is empty at reset
	localparam credit_t CREDIT_INIT = credit_t'(`NOC_BUFFER_DEPTH);

endpackage

//--- common/noc_router_config.svh
// *************************************************************************
// Router build constants
//   Input buffer depth, which also sets the initial output credit count
//   Input and output port counts
//   Credit counter and destination node widths
// *************************************************************************

`ifndef NOC_ROUTER_CONFIG_SVH
`define NOC_ROUTER_CONFIG_SVH

// Flit slots per input buffer
// Each output starts with this many downstream credits
`define NOC_BUFFER_DEPTH 4

// Port counts of the router stage
`define NOC_NUM_INPUTS 2
`define NOC_NUM_OUTPUTS 2

// Credit counters hold 0 up to NOC_BUFFER_DEPTH
`define NOC_CREDIT_BITS 3

// Destination node field width in a head flit
// Bit 1 of the node selects the output
`define NOC_NODE_BITS 2

`endif

//--- logic/noc_route_table.sv
// *************************************************************************
// Routing table
//   Decodes a destination node into a one-hot output request
//   Fixed rule for this stage, node bit 1 picks the output
// *************************************************************************

`include "noc_router_config.svh"

module noc_route_table
(
	input noc_flit_pkg::node_id_t dest,
	output noc_route_pkg::out_req_t out_req
);

	import noc_route_pkg::*;

	// Selected output index
	out_idx_t out_sel;

	// *********************************************************************
	// Route lookup
	// *********************************************************************

	// Node 0 and 1 -> output 0
	// Node 2 and 3 -> output 1
	// Another topology only changes this decode
	assign out_sel = out_idx_t'(dest[`NOC_NODE_BITS-1]);

	// *********************************************************************
	// One-hot request
	// *********************************************************************

	always_comb
	begin
		// Exactly one bit set for any destination
		out_req = '0;
		out_req[out_sel] = 1'b1;
	end

endmodule

//--- project.f
+incdir+common
common/noc_flit_pkg.sv
common/noc_route_pkg.sv
logic/noc_route_table.sv
router/noc_input_port.sv
router/noc_output_arbiter.sv
router/noc_router.sv
bench/noc_router_assertions.sv
bench/noc_router_tb.sv

//--- router/noc_input_port.sv
// *************************************************************************
// Router input port
//   Circular flit buffer, filled under credit flow control
//   Head-flit tracking and destination latch per packet
//   Route request from the buffer head, credit return per pop
// *************************************************************************

`include "noc_router_config.svh"

module noc_input_port
(
	input logic munoc_port_0,
	input logic munoc_port_4,
	input logic in_valid,
	input noc_flit_pkg::flit_t in_flit,
	output logic in_credit,
	input logic grant,
	output noc_flit_pkg::flit_t head_flit,
	output logic nonempty,
	output noc_route_pkg::out_req_t out_req
);

	import noc_flit_pkg::*;
	import noc_route_pkg::*;

	localparam int DEPTH = `NOC_BUFFER_DEPTH;
	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	// Flit storage
	flit_t buffer [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;

	// Occupancy, bounded by the credits handed out
	credit_t count;

	// Next flit at the head starts a new packet
	logic expect_head;

	// Destination of the packet in flight
	node_id_t dest_q;
	node_id_t route_dest;
	out_req_t table_req;

	logic push;
	logic pop;

	assign push = in_valid;
	assign pop = grant;

	// *********************************************************************
	// Flit buffer
	// *********************************************************************

	// Sender only sends with a credit, so a push never finds the buffer full
	always_ff @(posedge munoc_port_0)
	begin
		if (push)
			buffer[wr_ptr] <= in_flit;
	end

	always_ff @(posedge munoc_port_0 or negedge munoc_port_4)
	begin
		if (munoc_port_4 == 1'b0)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			// Pointers wrap at the last slot
			if (push)
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign head_flit = buffer[rd_ptr];
	assign nonempty = (count != '0);

	// *********************************************************************
	// Packet tracking
	// *********************************************************************

	always_ff @(posedge munoc_port_0 or negedge munoc_port_4)
	begin
		if (munoc_port_4 == 1'b0)
		begin
			expect_head <= 1'b1;
			dest_q <= '0;
			in_credit <= 1'b0;
		end
		else
		begin
			// A popped last flit means the next one is a head
			if (pop)
				expect_head <= flit_last(head_flit);
			// Keep the head's route for the body flits
			if (pop && expect_head)
				dest_q <= flit_dest(head_flit);
			// One credit back upstream per freed slot
			in_credit <= pop;
		end
	end

	// Head flit routes directly, body flits reuse the latched node
	assign route_dest = expect_head ? flit_dest(head_flit) : dest_q;

	noc_route_table u_route_table
	(
		.dest(route_dest),
		.out_req(table_req)
	);

	// No request without a flit at the head
	assign out_req = nonempty ? table_req : '0;

endmodule

//--- router/noc_output_arbiter.sv
// *************************************************************************
// Router output arbiter
//   Round-robin choice among requesting inputs
//   Packet lock so flits of two packets never interleave
//   Downstream credit counter and registered output link
// *************************************************************************

`include "noc_router_config.svh"

module noc_output_arbiter
(
	input logic munoc_port_0,
	input logic munoc_port_4,
	input noc_route_pkg::in_grant_t req,
	input noc_flit_pkg::flit_t flit0,
	input noc_flit_pkg::flit_t flit1,
	output noc_route_pkg::in_grant_t grant,
	output logic out_valid,
	output noc_flit_pkg::flit_t out_flit,
	input logic out_credit
);

	import noc_flit_pkg::*;
	import noc_route_pkg::*;

	localparam int NUM_IN = `NOC_NUM_INPUTS;

	// Credits left in the downstream buffer
	credit_t credits;

	// Packet lock
	logic locked;
	in_idx_t lock_idx;

	// Input with first priority when unlocked
	in_idx_t rr_ptr;

	in_idx_t sel_idx;
	logic sel_valid;
	logic grant_any;
	flit_t sel_flit;

	// *********************************************************************
	// Selection
	// *********************************************************************

	always_comb
	begin
		in_idx_t cand;
		cand = rr_ptr;
		sel_idx = rr_ptr;
		sel_valid = 1'b0;
		if (locked)
		begin
			// Only the owner of the packet may continue
			sel_idx = lock_idx;
			sel_valid = req[lock_idx];
		end
		else
		begin
			// Walk down so the input nearest the pointer wins
			for (int k = NUM_IN - 1; k >= 0; k--)
			begin
				cand = in_idx_t'((int'(rr_ptr) + k) % NUM_IN);
				if (req[cand])
				begin
					sel_idx = cand;
					sel_valid = 1'b1;
				end
			end
		end
	end

	assign sel_flit = (sel_idx == in_idx_t'(1)) ? flit1 : flit0;

	// No grant without a downstream slot
	assign grant_any = sel_valid && (credits != '0);
	assign grant = grant_any ? (in_grant_t'(1) << sel_idx) : '0;

	// *********************************************************************
	// Lock and round-robin pointer
	// *********************************************************************

	always_ff @(posedge munoc_port_0 or negedge munoc_port_4)
	begin
		if (munoc_port_4 == 1'b0)
		begin
			locked <= 1'b0;
			lock_idx <= '0;
			rr_ptr <= '0;
		end
		else if (grant_any)
		begin
			if (flit_last(sel_flit))
			begin
				// Packet done, priority moves past the winner
				locked <= 1'b0;
				rr_ptr <= in_idx_t'((int'(sel_idx) + 1) % NUM_IN);
			end
			else
			begin
				locked <= 1'b1;
				lock_idx <= sel_idx;
			end
		end
	end

	// *********************************************************************
	// Credit counter
	// *********************************************************************

	always_ff @(posedge munoc_port_0 or negedge munoc_port_4)
	begin
		if (munoc_port_4 == 1'b0)
			credits <= CREDIT_INIT;
		else
		begin
			// Spend on grant, refill on returned pulse
			case ({grant_any, out_credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// *********************************************************************
	// Output link
	// *********************************************************************

	always_ff @(posedge munoc_port_0 or negedge munoc_port_4)
	begin
		if (munoc_port_4 == 1'b0)
			out_valid <= 1'b0;
		else
			out_valid <= grant_any;
	end

	// Flit data only matters while out_valid is high
	always_ff @(posedge munoc_port_0)
	begin
		if (grant_any)
			out_flit <= sel_flit;
	end

endmodule

//--- router/noc_router.sv
// *************************************************************************
// Two-by-two wormhole router stage
//   Two credit-managed input ports
//   Two output arbiters with packet lock
// *************************************************************************

module noc_router
(
	input logic munoc_port_0,
	input logic munoc_port_4,
	// Input link 0
	input logic in0_valid,
	input noc_flit_pkg::flit_t in0_flit,
	output logic in0_credit,
	// Input link 1
	input logic in1_valid,
	input noc_flit_pkg::flit_t in1_flit,
	output logic in1_credit,
	// Output link 0
	output logic out0_valid,
	output noc_flit_pkg::flit_t out0_flit,
	input logic out0_credit,
	// Output link 1
	output logic out1_valid,
	output noc_flit_pkg::flit_t out1_flit,
	input logic out1_credit
);

	import noc_flit_pkg::*;
	import noc_route_pkg::*;

	// Input side
	flit_t in0_head;
	flit_t in1_head;
	logic in0_nonempty;
	logic in1_nonempty;
	out_req_t in0_req;
	out_req_t in1_req;
	logic in0_pop;
	logic in1_pop;

	// Output side, one bit per input
	in_grant_t out0_req;
	in_grant_t out1_req;
	in_grant_t out0_grant;
	in_grant_t out1_grant;

	// *********************************************************************
	// Request and grant crossbar
	// *********************************************************************

	// Each arbiter sees its own request bit from every input
	assign out0_req = {in1_req[0], in0_req[0]};
	assign out1_req = {in1_req[1], in0_req[1]};

	// Route is one-hot so at most one arbiter grants an input
	assign in0_pop = (out0_grant[0] | out1_grant[0]) & in0_nonempty;
	assign in1_pop = (out0_grant[1] | out1_grant[1]) & in1_nonempty;

	// *********************************************************************
	// Input ports
	// *********************************************************************

	noc_input_port u_in0
	(
		.munoc_port_0(munoc_port_0),
		.munoc_port_4(munoc_port_4),
		.in_valid(in0_valid),
		.in_flit(in0_flit),
		.in_credit(in0_credit),
		.grant(in0_pop),
		.head_flit(in0_head),
		.nonempty(in0_nonempty),
		.out_req(in0_req)
	);

	noc_input_port u_in1
	(
		.munoc_port_0(munoc_port_0),
		.munoc_port_4(munoc_port_4),
		.in_valid(in1_valid),
		.in_flit(in1_flit),
		.in_credit(in1_credit),
		.grant(in1_pop),
		.head_flit(in1_head),
		.nonempty(in1_nonempty),
		.out_req(in1_req)
	);

	// *********************************************************************
	// Output arbiters
	// *********************************************************************

	noc_output_arbiter u_out0
	(
		.munoc_port_0(munoc_port_0),
		.munoc_port_4(munoc_port_4),
		.req(out0_req),
		.flit0(in0_head),
		.flit1(in1_head),
		.grant(out0_grant),
		.out_valid(out0_valid),
		.out_flit(out0_flit),
		.out_credit(out0_credit)
	);

	noc_output_arbiter u_out1
	(
		.munoc_port_0(munoc_port_0),
		.munoc_port_4(munoc_port_4),
		.req(out1_req),
		.flit0(in0_head),
		.flit1(in1_head),
		.grant(out1_grant),
		.out_valid(out1_valid),
		.out_flit(out1_flit),
		.out_credit(out1_credit)
	);

endmodule
